// File: design/branchResolve.sv
// branch condition, mispredict detection and link value
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    input  exePkg::brKind_t           brKind_i,
    input  logic                      isLink_i,
    input  logic [exePkg::DATA_W-1:0] pc_i,
    input  logic [exePkg::DATA_W-1:0] regA_i,
    input  logic [exePkg::DATA_W-1:0] regB_i,
    input  logic [exePkg::DATA_W-1:0] target_i,    // pc plus offset from the ALU
    input  logic                      predTake_i,
    input  logic [exePkg::DATA_W-1:0] predDest_i,
    input  logic [exePkg::DATA_W-1:0] aluRes_i,
    output logic                      isBranch_o,
    output logic                      corrTake_o,
    output logic                      mispredict_o,
    output logic [exePkg::DATA_W-1:0] value_o
);

    logic aNeg;
    logic aZero;
    logic wrongDir;
    logic wrongDest;

    assign aNeg  = regA_i[exePkg::DATA_W-1];
    assign aZero = (regA_i == '0);

    ////////////////////////////////////////
    // condition on register values
    ////////////////////////////////////////
    always_comb begin
        case (brKind_i)
            exePkg::BR_EQ:  corrTake_o = (regA_i == regB_i);
            exePkg::BR_NE:  corrTake_o = (regA_i != regB_i);
            exePkg::BR_LTZ: corrTake_o = aNeg;
            exePkg::BR_LEZ: corrTake_o = aNeg || aZero;
            exePkg::BR_GTZ: corrTake_o = !aNeg && !aZero;
            exePkg::BR_GEZ: corrTake_o = !aNeg;
            default:        corrTake_o = 1'b0;   // not a branch
        endcase
    end

    assign isBranch_o = (brKind_i != exePkg::BR_NONE);

    assign wrongDir  = (corrTake_o != predTake_i);
    assign wrongDest = corrTake_o && predTake_i && (target_i != predDest_i);
    assign mispredict_o = isBranch_o && (wrongDir || wrongDest);

    // return address skips the delay slot
    assign value_o = isLink_i ? (pc_i + {{(exePkg::DATA_W-4){1'b0}}, 4'd8}) : aluRes_i;

endmodule

`default_nettype wire

// File: design/exeCtrl.sv
// stage control with issue/result valid bits, allow-in, flush and downstream credit counter
`timescale 1ns/1ps
`default_nettype none

module exeCtrl (
    input  logic clk,
    input  logic arstN_i,
    input  logic inValid_i,
    input  logic flush_i,
    input  logic creditRet_i,
    output logic allowIn_o,
    output logic issueLoad_o,
    output logic issueClear_o,
    output logic resultLoad_o,
    output logic resultClear_o,
    output logic outValid_o
);

    logic                        issueValid;
    logic                        resultValid;
    logic [exePkg::CREDIT_W-1:0] credits;
    logic                        sendOut;
    logic                        resultFree;
    logic                        issueMove;
    logic                        issueFree;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////
    // a flushed result never leaves
    assign sendOut    = resultValid && (credits != '0) && !flush_i;
    assign resultFree = !resultValid || sendOut;   // empty or draining
    assign issueMove  = issueValid && resultFree;
    assign issueFree  = !issueValid || issueMove;

    assign allowIn_o     = issueFree && !flush_i;
    assign issueLoad_o   = inValid_i && allowIn_o;
    assign issueClear_o  = flush_i;
    assign resultLoad_o  = issueMove && !flush_i;
    assign resultClear_o = flush_i;
    assign outValid_o    = sendOut;

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            issueValid  <= 1'b0;
            resultValid <= 1'b0;
            credits     <= exePkg::CREDIT_DEPTH;
        end else begin
            issueValid  <= !flush_i && (issueLoad_o || (issueValid && !issueMove));
            resultValid <= !flush_i && (resultLoad_o || (resultValid && !sendOut));
            // flush leaves the count alone
            case ({creditRet_i, sendOut})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    creditBound: assert property (@(posedge clk) disable iff (!arstN_i)
        credits <= exePkg::CREDIT_DEPTH);

    // receiver cannot return a slot it never got
    noReturnWhenFull: assert property (@(posedge clk) disable iff (!arstN_i)
        creditRet_i |-> (credits != exePkg::CREDIT_DEPTH));

endmodule

`default_nettype wire

// File: design/exePkg.sv
// execute stage widths, ALU and branch encodings, bypass selects, credit depth, payload structs
`default_nettype none

package exePkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int DATA_W = 32;
    localparam int REG_W  = 5;             // writeNum 0 means no write-back

    // one-hot bypass select, bit positions
    localparam int BYP_W   = 4;
    localparam int BYP_RF  = 0;            // register file read data
    localparam int BYP_EXE = 1;            // result register of this stage
    localparam int BYP_MEM = 2;
    localparam int BYP_WB  = 3;

    // downstream result slots
    localparam int CREDIT_W = 3;
    localparam logic [CREDIT_W-1:0] CREDIT_DEPTH = 3'd4;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI
    } aluOp_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LTZ, BR_LEZ, BR_GTZ, BR_GEZ
    } brKind_t;

    ////////////////////////////////////////
    // payloads
    ////////////////////////////////////////
    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [REG_W-1:0]  writeNum;
        logic [DATA_W-1:0] rsData;
        logic [DATA_W-1:0] rtData;
        logic [DATA_W-1:0] imm;        // branch offset for branches
        logic              isReg0;
        logic              isReg1;
        logic [BYP_W-1:0]  bypSel0;
        logic [BYP_W-1:0]  bypSel1;
        aluOp_t            aluOp;
        brKind_t           brKind;
        logic              isLink;
        logic              predTake;
        logic [DATA_W-1:0] predDest;
    } issue_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [REG_W-1:0]  writeNum;
        logic [DATA_W-1:0] value;
        logic              overflow;   // reported only, no trap
        logic              isBranch;
        logic              corrTake;
        logic [DATA_W-1:0] corrDest;
        logic              mispredict;
    } result_t;

endpackage

`default_nettype wire

// File: design/exeUpper.sv
// upper execute stage top: control, issue and result registers, operand select, ALU, branch
`timescale 1ns/1ps
`default_nettype none

module exeUpper (
    input  logic                      clk,
    input  logic                      arstN_i,
    // from decode
    input  logic                      inValid_i,
    output logic                      allowIn_o,
    input  logic [exePkg::DATA_W-1:0] inPc_i,
    input  logic [exePkg::REG_W-1:0]  inWriteNum_i,
    input  logic [exePkg::DATA_W-1:0] inRsData_i,
    input  logic [exePkg::DATA_W-1:0] inRtData_i,
    input  logic [exePkg::DATA_W-1:0] inImm_i,
    input  logic                      inIsReg0_i,
    input  logic                      inIsReg1_i,
    input  logic [exePkg::BYP_W-1:0]  inBypSel0_i,
    input  logic [exePkg::BYP_W-1:0]  inBypSel1_i,
    input  exePkg::aluOp_t            inAluOp_i,
    input  exePkg::brKind_t           inBrKind_i,
    input  logic                      inIsLink_i,
    input  logic                      inPredTake_i,
    input  logic [exePkg::DATA_W-1:0] inPredDest_i,
    // bypass, flush, credits
    input  logic [exePkg::DATA_W-1:0] memRes_i,
    input  logic [exePkg::DATA_W-1:0] wbRes_i,
    input  logic                      flush_i,
    input  logic                      creditRet_i,
    // downstream
    output logic                      outValid_o,
    output logic [exePkg::DATA_W-1:0] outPc_o,
    output logic [exePkg::REG_W-1:0]  outWriteNum_o,
    output logic [exePkg::DATA_W-1:0] value_o,
    output logic                      overflow_o,
    output logic                      isBranch_o,
    output logic                      corrTake_o,
    output logic [exePkg::DATA_W-1:0] corrDest_o,
    output logic                      mispredict_o
);

    exePkg::issue_t            issueD, issueQ;
    exePkg::result_t           resultD, resultQ;
    logic                      issueLoad, issueClear, resultLoad, resultClear;
    logic [exePkg::DATA_W-1:0] src0Imm;
    logic [exePkg::DATA_W-1:0] src0, src1, regA, regB, aluRes;

    ////////////////////////////////////////
    // control and registers
    ////////////////////////////////////////
    exeCtrl ctrl (
        .clk(clk), .arstN_i(arstN_i), .inValid_i(inValid_i), .flush_i(flush_i),
        .creditRet_i(creditRet_i), .allowIn_o(allowIn_o), .issueLoad_o(issueLoad),
        .issueClear_o(issueClear), .resultLoad_o(resultLoad),
        .resultClear_o(resultClear), .outValid_o(outValid_o)
    );

    assign issueD = '{pc: inPc_i, writeNum: inWriteNum_i, rsData: inRsData_i,
                      rtData: inRtData_i, imm: inImm_i, isReg0: inIsReg0_i,
                      isReg1: inIsReg1_i, bypSel0: inBypSel0_i, bypSel1: inBypSel1_i,
                      aluOp: inAluOp_i, brKind: inBrKind_i, isLink: inIsLink_i,
                      predTake: inPredTake_i, predDest: inPredDest_i};

    stageReg #(.payload_t(exePkg::issue_t)) issueReg (
        .clk(clk), .arstN_i(arstN_i), .load_i(issueLoad), .clear_i(issueClear),
        .d_i(issueD), .q_o(issueQ)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    // branch target base is the pc, offset comes in imm
    assign src0Imm = (issueQ.brKind != exePkg::BR_NONE) ? issueQ.pc : issueQ.imm;

    operandBypass byp0 (
        .clk(clk), .isReg_i(issueQ.isReg0), .bypSel_i(issueQ.bypSel0),
        .rfData_i(issueQ.rsData), .imm_i(src0Imm), .exeRes_i(resultQ.value),
        .memRes_i(memRes_i), .wbRes_i(wbRes_i), .operand_o(src0), .regValue_o(regA)
    );

    operandBypass byp1 (
        .clk(clk), .isReg_i(issueQ.isReg1), .bypSel_i(issueQ.bypSel1),
        .rfData_i(issueQ.rtData), .imm_i(issueQ.imm), .exeRes_i(resultQ.value),
        .memRes_i(memRes_i), .wbRes_i(wbRes_i), .operand_o(src1), .regValue_o(regB)
    );

    intAlu alu (
        .aluOp_i(issueQ.aluOp), .src0_i(src0), .src1_i(src1),
        .result_o(aluRes), .overflow_o(resultD.overflow)
    );

    branchResolve br (
        .brKind_i(issueQ.brKind), .isLink_i(issueQ.isLink), .pc_i(issueQ.pc),
        .regA_i(regA), .regB_i(regB), .target_i(aluRes), .predTake_i(issueQ.predTake),
        .predDest_i(issueQ.predDest), .aluRes_i(aluRes), .isBranch_o(resultD.isBranch),
        .corrTake_o(resultD.corrTake), .mispredict_o(resultD.mispredict),
        .value_o(resultD.value)
    );

    assign resultD.pc       = issueQ.pc;
    assign resultD.writeNum = issueQ.writeNum;
    assign resultD.corrDest = aluRes;

    stageReg #(.payload_t(exePkg::result_t)) resultReg (
        .clk(clk), .arstN_i(arstN_i), .load_i(resultLoad), .clear_i(resultClear),
        .d_i(resultD), .q_o(resultQ)
    );

    // value_o doubles as the EXE bypass source
    assign outPc_o       = resultQ.pc;
    assign outWriteNum_o = resultQ.writeNum;
    assign value_o       = resultQ.value;
    assign overflow_o    = resultQ.overflow;
    assign isBranch_o    = resultQ.isBranch;
    assign corrTake_o    = resultQ.corrTake;
    assign corrDest_o    = resultQ.corrDest;
    assign mispredict_o  = resultQ.mispredict;

endmodule

`default_nettype wire

// File: design/intAlu.sv
// 32-bit integer ALU, signed add/sub overflow flag
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input  exePkg::aluOp_t            aluOp_i,
    input  logic [exePkg::DATA_W-1:0] src0_i,
    input  logic [exePkg::DATA_W-1:0] src1_i,
    output logic [exePkg::DATA_W-1:0] result_o,
    output logic                      overflow_o
);

    localparam int MSB = exePkg::DATA_W - 1;

    logic [exePkg::DATA_W-1:0] addRes;
    logic [exePkg::DATA_W-1:0] subRes;
    logic [4:0]                shamt;
    logic                      addOvf;
    logic                      subOvf;
    logic                      ltSigned;
    logic                      ltUnsigned;

    assign addRes = src0_i + src1_i;
    assign subRes = src0_i - src1_i;
    assign shamt  = src0_i[4:0];          // variable shifts, rs side

    // same-sign inputs with a sign flip in the sum
    assign addOvf = (src0_i[MSB] == src1_i[MSB]) && (addRes[MSB] != src0_i[MSB]);
    assign subOvf = (src0_i[MSB] != src1_i[MSB]) && (subRes[MSB] != src0_i[MSB]);

    assign ltSigned   = $signed(src0_i) < $signed(src1_i);
    assign ltUnsigned = src0_i < src1_i;

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////
    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (aluOp_i)
            exePkg::ALU_ADD: begin
                result_o   = addRes;
                overflow_o = addOvf;
            end
            exePkg::ALU_ADDU: result_o = addRes;
            exePkg::ALU_SUB: begin
                result_o   = subRes;
                overflow_o = subOvf;
            end
            exePkg::ALU_AND:  result_o = src0_i & src1_i;
            exePkg::ALU_OR:   result_o = src0_i | src1_i;
            exePkg::ALU_XOR:  result_o = src0_i ^ src1_i;
            exePkg::ALU_NOR:  result_o = ~(src0_i | src1_i);
            exePkg::ALU_SLL:  result_o = src1_i << shamt;
            exePkg::ALU_SRL:  result_o = src1_i >> shamt;
            exePkg::ALU_SRA:  result_o = $signed(src1_i) >>> shamt;
            exePkg::ALU_SLT:  result_o = {{MSB{1'b0}}, ltSigned};
            exePkg::ALU_SLTU: result_o = {{MSB{1'b0}}, ltUnsigned};
            exePkg::ALU_LUI:  result_o = {src1_i[15:0], 16'h0000};
            default:          result_o = '0;    // unused opcodes
        endcase
    end

endmodule

`default_nettype wire

// File: design/operandBypass.sv
// source operand select: register file, immediate or one of three bypass values
`timescale 1ns/1ps
`default_nettype none

module operandBypass (
    input  logic                      clk,          // only for the select check
    input  logic                      isReg_i,
    input  logic [exePkg::BYP_W-1:0]  bypSel_i,
    input  logic [exePkg::DATA_W-1:0] rfData_i,
    input  logic [exePkg::DATA_W-1:0] imm_i,
    input  logic [exePkg::DATA_W-1:0] exeRes_i,
    input  logic [exePkg::DATA_W-1:0] memRes_i,
    input  logic [exePkg::DATA_W-1:0] wbRes_i,
    output logic [exePkg::DATA_W-1:0] operand_o,
    output logic [exePkg::DATA_W-1:0] regValue_o
);

    ////////////////////////////////////////
    // one-hot and-or select
    ////////////////////////////////////////
    assign regValue_o =
        ({exePkg::DATA_W{bypSel_i[exePkg::BYP_RF]}}  & rfData_i) |
        ({exePkg::DATA_W{bypSel_i[exePkg::BYP_EXE]}} & exeRes_i) |
        ({exePkg::DATA_W{bypSel_i[exePkg::BYP_MEM]}} & memRes_i) |
        ({exePkg::DATA_W{bypSel_i[exePkg::BYP_WB]}}  & wbRes_i);

    assign operand_o = isReg_i ? regValue_o : imm_i;

    // branches compare regValue_o even when the ALU takes the immediate,
    // so the select must be clean whatever isReg_i says
    bypSelOneHot: assert property (@(posedge clk) $onehot0(bypSel_i));

endmodule

`default_nettype wire

// File: design/stageReg.sv
// pipeline register with load and clear, generic over its payload type
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arstN_i,
    input  logic     load_i,
    input  logic     clear_i,   // wins over load_i
    input  payload_t d_i,
    output payload_t q_o
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            q_o <= '0;
        end else if (clear_i) begin
            q_o <= '0;
        end else if (load_i) begin
            q_o <= d_i;
        end
        // otherwise hold, e.g. under back-pressure
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+testbench
design/exePkg.sv
design/stageReg.sv
design/exeCtrl.sv
design/operandBypass.sv
design/intAlu.sv
design/branchResolve.sv
design/exeUpper.sv
testbench/tbExeUpper.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
# the run passes only if the pass line shows up in the output

verilator --binary --timing --assert -f filelist.f --top-module tbExeUpper -o simExe \
    && ./obj_dir/simExe | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/exeModel.svh
// reference functions for the ALU, bypass source selection and branch conditions
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH
`default_nettype none

// ALU behavior, overflow taken from a 33-bit signed sum
function automatic logic [31:0] aluModel(input exePkg::aluOp_t op, input logic [31:0] a,
                                         input logic [31:0] b, output logic ovf);
    logic signed [32:0] wide;
    logic [31:0]        res;
    ovf  = 1'b0;
    wide = '0;
    case (op)
        exePkg::ALU_ADD: begin
            wide = {a[31], a} + {b[31], b};
            res  = wide[31:0];
            ovf  = wide[32] != wide[31];
        end
        exePkg::ALU_ADDU: res = a + b;
        exePkg::ALU_SUB: begin
            wide = {a[31], a} - {b[31], b};
            res  = wide[31:0];
            ovf  = wide[32] != wide[31];
        end
        exePkg::ALU_AND:  res = a & b;
        exePkg::ALU_OR:   res = a | b;
        exePkg::ALU_XOR:  res = a ^ b;
        exePkg::ALU_NOR:  res = ~(a | b);
        exePkg::ALU_SLL:  res = b << a[4:0];
        exePkg::ALU_SRL:  res = b >> a[4:0];
        exePkg::ALU_SRA:  res = $signed(b) >>> a[4:0];
        exePkg::ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exePkg::ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
        exePkg::ALU_LUI:  res = {b[15:0], 16'h0000};
        default:          res = '0;
    endcase
    return res;
endfunction

// register value picked by a one-hot select, zero when nothing selected
function automatic logic [31:0] selSource(input logic [3:0] sel, input logic [31:0] rf,
                                          input logic [31:0] exe, input logic [31:0] mem,
                                          input logic [31:0] wb);
    case (sel)
        4'b0001: return rf;
        4'b0010: return exe;
        4'b0100: return mem;
        4'b1000: return wb;
        default: return '0;
    endcase
endfunction

function automatic logic branchTaken(input exePkg::brKind_t kind, input logic [31:0] a,
                                     input logic [31:0] b);
    case (kind)
        exePkg::BR_EQ:  return a == b;
        exePkg::BR_NE:  return a != b;
        exePkg::BR_LTZ: return $signed(a) < 0;
        exePkg::BR_LEZ: return $signed(a) <= 0;
        exePkg::BR_GTZ: return $signed(a) > 0;
        exePkg::BR_GEZ: return $signed(a) >= 0;
        default:        return 1'b0;
    endcase
endfunction

`default_nettype wire
`endif

// File: testbench/tbExeUpper.sv
// upper execute stage testbench with clock, reset, directed tests, scoreboard and timeout
`timescale 1ns/1ps
`include "exeModel.svh"
`default_nettype none

module tbExeUpper;

    localparam int MAX_CYCLES = 2000;
    localparam int RET_DELAY  = 2;       // cycles from result to credit return

    logic clk = 1'b0;
    logic arstN_i;
    logic inValid_i, allowIn_o, inIsReg0_i, inIsReg1_i, inIsLink_i, inPredTake_i;
    logic [31:0] inPc_i, inRsData_i, inRtData_i, inImm_i, inPredDest_i, memRes_i, wbRes_i;
    logic [4:0]  inWriteNum_i;
    logic [3:0]  inBypSel0_i, inBypSel1_i;
    exePkg::aluOp_t  inAluOp_i;
    exePkg::brKind_t inBrKind_i;
    logic flush_i, creditRet_i;
    logic outValid_o, overflow_o, isBranch_o, corrTake_o, mispredict_o;
    logic [31:0] outPc_o, value_o, corrDest_o;
    logic [4:0]  outWriteNum_o;

    exePkg::result_t expQ[$];
    int accQ[$];
    int retDue[$];
    int cycle = 0;
    int runCycles = 0;
    int valueErr = 0;
    int otherErr = 0;
    int outstanding = 0;
    int sentCount = 0;
    int acceptCount = 0;
    logic accepted = 1'b0;
    logic holdCredits = 1'b0;
    logic checkLatency = 1'b0;
    logic [31:0] lastValue = '0;   // what the result register holds for EXE bypass

    exeUpper dut (.*);

    always #2 clk = ~clk;

    // watchdog over the whole run
    always @(posedge clk) begin
        runCycles++;
        if (runCycles >= MAX_CYCLES) begin
            $display("timeout: run reached %0d cycles", runCycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////
    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            valueErr++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            valueErr++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic exePkg::result_t buildExpected();
        exePkg::result_t r;
        logic [31:0] regA, regB, src0, src1, aluV;
        logic ovf;
        regA = selSource(inBypSel0_i, inRsData_i, lastValue, memRes_i, wbRes_i);
        regB = selSource(inBypSel1_i, inRtData_i, lastValue, memRes_i, wbRes_i);
        // branch target is pc plus offset
        src0 = inIsReg0_i ? regA : ((inBrKind_i != exePkg::BR_NONE) ? inPc_i : inImm_i);
        src1 = inIsReg1_i ? regB : inImm_i;
        aluV = aluModel(inAluOp_i, src0, src1, ovf);
        r.pc         = inPc_i;
        r.writeNum   = inWriteNum_i;
        r.value      = inIsLink_i ? inPc_i + 32'd8 : aluV;
        r.overflow   = ovf;
        r.isBranch   = inBrKind_i != exePkg::BR_NONE;
        r.corrTake   = branchTaken(inBrKind_i, regA, regB);
        r.corrDest   = aluV;
        r.mispredict = r.isBranch && ((r.corrTake != inPredTake_i) ||
                       (r.corrTake && inPredTake_i && aluV != inPredDest_i));
        return r;
    endfunction

    // samples mid low phase and steps to the next falling edge
    task automatic tick();
        exePkg::result_t exp;
        int acc;
        #1;
        if (flush_i) begin
            expQ.delete();
            accQ.delete();
            lastValue = '0;
        end
        if (outValid_o) begin
            outstanding++;
            sentCount++;
            retDue.push_back(cycle + RET_DELAY);
            assert (expQ.size() != 0) else begin
                otherErr++;
                $display("unexpected result at %0t with nothing pending", $time);
            end
            if (expQ.size() != 0) begin
                exp = expQ.pop_front();
                acc = accQ.pop_front();
                checkWord("outPc_o", outPc_o, exp.pc);
                checkWord("outWriteNum_o", {27'b0, outWriteNum_o}, {27'b0, exp.writeNum});
                checkWord("value_o", value_o, exp.value);
                checkBit("overflow_o", overflow_o, exp.overflow);
                checkBit("isBranch_o", isBranch_o, exp.isBranch);
                checkBit("corrTake_o", corrTake_o, exp.corrTake);
                checkWord("corrDest_o", corrDest_o, exp.corrDest);
                checkBit("mispredict_o", mispredict_o, exp.mispredict);
                if (checkLatency) begin
                    assert (cycle - acc == 2) else begin
                        otherErr++;
                        $display("result at %0t came %0d cycles after acceptance",
                                 $time, cycle - acc);
                    end
                end
            end
        end
        if (creditRet_i) outstanding--;
        accepted = inValid_i && allowIn_o;
        if (accepted) begin
            exp = buildExpected();
            expQ.push_back(exp);
            accQ.push_back(cycle);
            lastValue = exp.value;
            acceptCount++;
        end
        @(posedge clk);
        @(negedge clk);
        cycle++;
        creditRet_i = 1'b0;
        if (!holdCredits && retDue.size() != 0 && retDue[0] <= cycle) begin
            void'(retDue.pop_front());
            creditRet_i = 1'b1;
        end
    endtask

    task automatic setInstr(input exePkg::aluOp_t op, input logic r0, input logic r1,
                            input logic [31:0] rs, input logic [31:0] rt,
                            input logic [31:0] imm);
        inAluOp_i    = op;
        inIsReg0_i   = r0;
        inIsReg1_i   = r1;
        inRsData_i   = rs;
        inRtData_i   = rt;
        inImm_i      = imm;
        inBypSel0_i  = 4'b0001;
        inBypSel1_i  = 4'b0001;
        inBrKind_i   = exePkg::BR_NONE;
        inIsLink_i   = 1'b0;
        inPredTake_i = 1'b0;
        inPredDest_i = '0;
        inPc_i       = $urandom() & 32'hffff_fffc;
        inWriteNum_i = 5'($urandom());
    endtask

    task automatic issue();
        inValid_i = 1'b1;
        do tick(); while (!accepted);
        inValid_i = 1'b0;
    endtask

    task automatic drain();
        while (expQ.size() != 0 || outstanding != 0) tick();
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic aluTest();
        for (int op = 0; op <= 12; op++) begin
            repeat (4) begin
                setInstr(exePkg::aluOp_t'(op), 1'b1, 1'b1, $urandom(), $urandom(), $urandom());
                issue();
                setInstr(exePkg::aluOp_t'(op), 1'b1, 1'b0, $urandom(), $urandom(), $urandom());
                issue();
            end
        end
        // signed overflow corners
        setInstr(exePkg::ALU_ADD, 1'b1, 1'b1, 32'h7fff_ffff, 32'h1, '0);
        issue();
        setInstr(exePkg::ALU_ADD, 1'b1, 1'b1, 32'h8000_0000, 32'h8000_0000, '0);
        issue();
        setInstr(exePkg::ALU_SUB, 1'b1, 1'b1, 32'h8000_0000, 32'h1, '0);
        issue();
        setInstr(exePkg::ALU_SUB, 1'b1, 1'b1, 32'h7fff_ffff, 32'hffff_ffff, '0);
        issue();
        drain();
    endtask

    task automatic bypassTest();
        memRes_i = $urandom();
        wbRes_i  = $urandom();
        for (int s = 0; s < 4; s++) begin
            setInstr(exePkg::ALU_ADDU, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            inBypSel0_i = 4'b0001 << s;
            issue();
            setInstr(exePkg::ALU_XOR, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            inBypSel1_i = 4'b0001 << s;
            issue();
        end
        repeat (5) begin   // back-to-back dependence chain
            setInstr(exePkg::ALU_ADDU, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            inBypSel0_i = 4'b0010;
            issue();
        end
        drain();
    endtask

    task automatic branchTest();
        logic [31:0] aVals[3];
        logic [31:0] target;
        logic taken;
        aVals = '{32'd0, 32'd5, 32'hffff_fffd};
        for (int k = 1; k <= 6; k++) begin
            for (int i = 0; i < 3; i++) begin
                for (int p = 0; p < 3; p++) begin
                    setInstr(exePkg::ALU_ADD, 1'b0, 1'b0, aVals[i], 32'd5,
                             $urandom() & 32'h0000_fffc);
                    inBrKind_i = exePkg::brKind_t'(k);
                    inIsLink_i = (p == 2) && (k == 6);
                    target = inPc_i + inImm_i;
                    taken = branchTaken(inBrKind_i, aVals[i], 32'd5);
                    // right, wrong direction, wrong target
                    inPredTake_i = (p == 1) ? !taken : taken;
                    inPredDest_i = (p == 2) ? target + 32'd4 : target;
                    issue();
                end
            end
        end
        setInstr(exePkg::ALU_ADDU, 1'b1, 1'b1, $urandom(), $urandom(), '0);
        inIsLink_i = 1'b1;     // jump-and-link without a condition
        issue();
        drain();
    endtask

    task automatic latencyTest();
        int start;
        checkLatency = 1'b1;
        start = cycle;
        repeat (8) begin
            setInstr(exePkg::ALU_OR, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            issue();
        end
        assert (cycle - start == 8) else begin
            otherErr++;
            $display("8 instructions took %0d cycles to be accepted", cycle - start);
        end
        drain();
        checkLatency = 1'b0;
    endtask

    task automatic backPressureTest();
        holdCredits = 1'b1;
        acceptCount = 0;
        sentCount = 0;
        inValid_i = 1'b1;
        repeat (12) begin
            setInstr(exePkg::ALU_SUB, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            tick();
        end
        inValid_i = 1'b0;
        assert (acceptCount == 6 && sentCount == 4 && !allowIn_o) else begin
            otherErr++;
            $display("back-pressure: %0d accepted, %0d sent, allowIn %b",
                     acceptCount, sentCount, allowIn_o);
        end
        holdCredits = 1'b0;
        drain();
        assert (sentCount == 6) else begin
            otherErr++;
            $display("back-pressure: %0d results sent after release, 6 wanted", sentCount);
        end
    endtask

    task automatic flushTest();
        repeat (3) begin
            setInstr(exePkg::ALU_ADDU, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            issue();
        end
        flush_i = 1'b1;
        inValid_i = 1'b1;
        tick();
        flush_i = 1'b0;
        inValid_i = 1'b0;
        // first of the three has left, its credit not yet back
        assert (dut.ctrl.credits == exePkg::CREDIT_DEPTH - 3'd1) else begin
            otherErr++;
            $display("credit count changed by flush, now %0d", dut.ctrl.credits);
        end
        repeat (4) tick();
        repeat (3) begin
            setInstr(exePkg::ALU_AND, 1'b1, 1'b1, $urandom(), $urandom(), '0);
            issue();
        end
        drain();
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'h868f79fb));
        arstN_i = 1'b0;
        inValid_i = 1'b0;
        flush_i = 1'b0;
        creditRet_i = 1'b0;
        memRes_i = '0;
        wbRes_i = '0;
        setInstr(exePkg::ALU_ADD, 1'b0, 1'b0, '0, '0, '0);
        repeat (8) @(negedge clk);
        arstN_i = 1'b1;
        @(negedge clk);
        assert (allowIn_o && !outValid_o) else begin
            otherErr++;
            $display("after reset allowIn %b outValid %b", allowIn_o, outValid_o);
        end
        aluTest();
        bypassTest();
        branchTest();
        latencyTest();
        backPressureTest();
        flushTest();
        $display("errors: %0d value mismatches, %0d other failures", valueErr, otherErr);
        if (valueErr == 0 && otherErr == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
